/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_jmp,
    input  logic                i_hld,
    input  rv_core_pkg::fetch_t i_fetch,
    input  rv_core_pkg::rf_wr_t i_rf_wr,
    output rv_core_pkg::exec_t  o_exec,
    output logic                o_s1_jump,
    output logic                o_s1_store,
    output logic                o_illegal,
    output logic [`RV_XLEN-1:0] o_s1_pc
);

    rv_core_pkg::fetch_t  s1;
    logic [`RV_XLEN-1:0]  rf [`RV_NREG];
    logic [`RV_ILEN-1:0]  ir;
    logic [6:0]           funct7;
    logic [2:0]           funct3;
    logic [4:0]           rd, rs1, rs2;
    logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`RV_XLEN-1:0]  rs1_val, rs2_val;
    logic                 take;
    logic                 bad;
    rv_core_pkg::alu_op_e arith_op;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1.valid <= 1'b0;
        end else if (i_jmp) begin
            s1.valid <= 1'b0;
        end else if (!i_hld) begin
            s1 <= i_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rf_wr.en) begin
            rf[i_rf_wr.idx] <= i_rf_wr.data;
        end
    end

    // same-cycle writeback wins over the array
    function automatic logic [`RV_XLEN-1:0] read_reg(input logic [`RV_REG_IDX_W-1:0] idx,
                                                     input rv_core_pkg::rf_wr_t    wr,
                                                     input logic [`RV_XLEN-1:0]    stored);
        if (wr.en && wr.idx == idx) begin
            return wr.data;
        end
        if (idx == '0) begin
            return '0;
        end
        return stored;
    endfunction

    assign ir      = s1.ir;
    assign funct7  = ir[31:25];
    assign funct3  = ir[14:12];
    assign rs2     = ir[24:20];
    assign rs1     = ir[19:15];
    assign rd      = ir[11:7];
    assign imm_i   = {{20{ir[31]}}, ir[31:20]};
    assign imm_s   = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b   = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u   = {ir[31:12], 12'd0};
    assign imm_j   = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign rs1_val = read_reg(rs1[3:0], i_rf_wr, rf[rs1[3:0]]);
    assign rs2_val = read_reg(rs2[3:0], i_rf_wr, rf[rs2[3:0]]);

    always_comb begin
        case (funct3)
            3'd1:    arith_op = rv_core_pkg::ALU_SLL;
            3'd2:    arith_op = rv_core_pkg::ALU_SLT;
            3'd3:    arith_op = rv_core_pkg::ALU_SLTU;
            3'd4:    arith_op = rv_core_pkg::ALU_XOR;
            3'd5:    arith_op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'd6:    arith_op = rv_core_pkg::ALU_OR;
            3'd7:    arith_op = rv_core_pkg::ALU_AND;
            default: arith_op = (ir[5] & funct7[5]) ? rv_core_pkg::ALU_SUB
                                                    : rv_core_pkg::ALU_ADD;  // ir[5] marks OP
        endcase
        case (funct3[2:1])
            2'b10:   take = funct3[0] ^ ($signed(rs1_val) < $signed(rs2_val));
            2'b11:   take = funct3[0] ^ (rs1_val < rs2_val);
            default: take = funct3[0] ^ (rs1_val == rs2_val);
        endcase
    end

    always_comb begin
        o_exec            = '0;
        o_exec.rd         = rd[3:0];
        o_exec.alu_a      = rs1_val;
        o_exec.alu_b      = imm_i;
        o_exec.alu_op     = rv_core_pkg::ALU_ADD;
        o_exec.wb_op      = rv_core_pkg::WB_STD;
        o_exec.link       = s1.pc + 32'd4;
        o_exec.store_data = rs2_val;
        bad               = rd[4];
        case (rv_core_pkg::opcode_e'(ir[6:0]))
            rv_core_pkg::OPC_LUI: begin
                o_exec.alu_a = '0;
                o_exec.alu_b = imm_u;
            end
            rv_core_pkg::OPC_AUIPC: begin
                o_exec.alu_a = s1.pc;
                o_exec.alu_b = imm_u;
            end
            rv_core_pkg::OPC_JAL: begin
                o_exec.alu_a = s1.pc;
                o_exec.alu_b = imm_j;
                o_exec.wb_op = rv_core_pkg::WB_LINK;
                o_exec.jump  = 1'b1;
            end
            rv_core_pkg::OPC_JALR: begin
                o_exec.wb_op = rv_core_pkg::WB_JALR;
                o_exec.jump  = 1'b1;
                bad          = rd[4] | rs1[4] | (funct3 != 3'd0);
            end
            rv_core_pkg::OPC_BRANCH: begin
                o_exec.rd    = '0;
                o_exec.alu_a = s1.pc;
                o_exec.alu_b = imm_b;  // target computed in s2
                o_exec.wb_op = rv_core_pkg::WB_STORE;
                o_exec.jump  = take;
                bad          = rs1[4] | rs2[4] | (funct3[2:1] == 2'b01);
            end
            rv_core_pkg::OPC_STORE: begin
                o_exec.rd       = '0;
                o_exec.alu_b    = imm_s;
                o_exec.wb_op    = rv_core_pkg::WB_STORE;
                o_exec.is_store = 1'b1;
                bad             = rs1[4] | rs2[4] | (funct3 != 3'b010);  // SW only
            end
            rv_core_pkg::OPC_OPIMM: begin
                o_exec.alu_op = arith_op;
                bad = rd[4] | rs1[4] | ((funct3[1:0] == 2'b01) &&
                      (funct7 != {1'b0, funct3[2] & funct7[5], 5'd0}));
            end
            rv_core_pkg::OPC_OP: begin
                o_exec.alu_b  = rs2_val;
                o_exec.alu_op = arith_op;
                bad = rd[4] | rs1[4] | rs2[4] | (funct7 !=
                      {1'b0, funct7[5] & (funct3 == 3'd0 || funct3 == 3'd5), 5'd0});
            end
            default: bad = 1'b1;
        endcase
        o_exec.valid = s1.valid & ~bad;
    end

    assign o_s1_jump  = o_exec.valid & o_exec.jump;
    assign o_s1_store = o_exec.valid & o_exec.is_store;
    assign o_illegal  = s1.valid & bad & ~i_hld;  // wrong-path words sit in s1 under hold
    assign o_s1_pc    = s1.pc;

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_hld,
    input  rv_core_pkg::exec_t    i_exec,
    input  logic                  i_illegal,
    input  logic [`RV_XLEN-1:0]   i_s1_pc,
    output rv_core_pkg::rf_wr_t   o_rf_wr,
    output logic [`RV_XLEN-1:0]   o_jmp_addr,
    output rv_core_pkg::bus_req_t o_dbus,
    input  logic                  i_dbus_resp,
    output logic                  o_store_done,
    output logic                  o_core_fault,
    output logic [`RV_XLEN-1:0]   o_core_fault_pc
);

    rv_core_pkg::exec_t  s2;
    logic [`RV_XLEN-1:0] alu_r;
    logic [4:0]          shamt;
    logic                dbus_vld;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2.valid <= 1'b0;
        end else if (!i_hld) begin
            s2 <= i_exec;
        end else if (o_store_done) begin
            s2.is_store <= 1'b0;  // store served, no second request
        end
    end

    assign shamt = s2.alu_b[4:0];

    always_comb begin
        case (s2.alu_op)
            rv_core_pkg::ALU_SUB:  alu_r = s2.alu_a - s2.alu_b;
            rv_core_pkg::ALU_AND:  alu_r = s2.alu_a & s2.alu_b;
            rv_core_pkg::ALU_OR:   alu_r = s2.alu_a | s2.alu_b;
            rv_core_pkg::ALU_XOR:  alu_r = s2.alu_a ^ s2.alu_b;
            rv_core_pkg::ALU_SLT:  alu_r = {31'd0, $signed(s2.alu_a) < $signed(s2.alu_b)};
            rv_core_pkg::ALU_SLTU: alu_r = {31'd0, s2.alu_a < s2.alu_b};
            rv_core_pkg::ALU_SLL:  alu_r = s2.alu_a << shamt;
            rv_core_pkg::ALU_SRL:  alu_r = s2.alu_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_r = $signed(s2.alu_a) >>> shamt;
            default:               alu_r = s2.alu_a + s2.alu_b;
        endcase
    end

    // written only in the cycle s2 moves on
    assign o_rf_wr.en   = s2.valid & ~i_hld & (s2.wb_op != rv_core_pkg::WB_STORE) &
                          (s2.rd != '0);
    assign o_rf_wr.idx  = s2.rd;
    assign o_rf_wr.data = s2.jump ? s2.link : alu_r;

    assign o_jmp_addr = {alu_r[`RV_XLEN-1:1], alu_r[0] & (s2.wb_op != rv_core_pkg::WB_JALR)};

    // request rises one cycle after s2 takes the store
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dbus_vld <= 1'b0;
        end else if (dbus_vld) begin
            dbus_vld <= ~i_dbus_resp;
        end else begin
            dbus_vld <= s2.valid & s2.is_store;
        end
    end

    assign o_store_done = dbus_vld & i_dbus_resp;
    assign o_dbus       = '{valid: dbus_vld, addr: alu_r, wdata: s2.store_data};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_core_fault <= 1'b0;
        end else if (i_illegal && !o_core_fault) begin
            o_core_fault    <= 1'b1;  // sticky, first one kept
            o_core_fault_pc <= i_s1_pc;
        end
    end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_jmp,
    input  logic [`RV_XLEN-1:0]   i_jmp_addr,
    input  logic                  i_hld,
    output rv_core_pkg::bus_req_t o_ibus,
    input  logic                  i_ibus_resp,
    input  logic [`RV_XLEN-1:0]   i_ibus_rdata,
    output rv_core_pkg::fetch_t   o_fetch,
    output logic                  o_ifetch_done
);

    logic [`RV_XLEN-1:0] pc;        // next address to fetch
    logic [`RV_XLEN-1:0] req_addr;  // address of the outstanding fetch
    logic                busy;
    logic                cancel;    // response owed from before a jump
    logic                start;
    rv_core_pkg::fetch_t fbuf;

    // launch only when the returned word has a free slot
    assign start         = ~busy & ~i_jmp & (~fbuf.valid | ~i_hld);
    assign o_ifetch_done = busy & i_ibus_resp & ~cancel;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc     <= `RV_RESET_PC;
            busy   <= 1'b0;
            cancel <= 1'b0;
        end else begin
            if (i_jmp) begin
                pc <= i_jmp_addr;
            end else if (start) begin
                pc <= pc + 32'd4;
            end
            busy   <= start | (busy & ~i_ibus_resp);
            cancel <= i_jmp ? (busy & ~i_ibus_resp) : (cancel & ~i_ibus_resp);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= pc;  // held stable until the response
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fbuf.valid <= 1'b0;
        end else if (i_jmp) begin
            fbuf.valid <= 1'b0;  // wrong-path word
        end else if (o_ifetch_done) begin
            fbuf <= '{valid: 1'b1, ir: i_ibus_rdata, pc: req_addr};
        end else if (!i_hld) begin
            fbuf.valid <= 1'b0;  // taken by s1
        end
    end

    assign o_ibus  = '{valid: busy, addr: req_addr, wdata: '0};
    assign o_fetch = fbuf;

endmodule

/* hdl/pipeline_ctrl.sv */
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic i_s1_jump,
    input  logic i_s1_store,
    input  logic i_ifetch_launch,
    input  logic i_ifetch_done,
    input  logic i_dbus_launch,
    input  logic i_store_done,
    output logic o_jmp,
    output logic o_hld
);

    rv_core_pkg::plc_state_e state, next_state, pick;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= rv_core_pkg::PLC_NORMAL;
        end else begin
            state <= next_state;
        end
    end

    // decision on the instruction now in s1
    assign pick = i_s1_jump  ? rv_core_pkg::PLC_JUMP_P :
                  i_s1_store ? rv_core_pkg::PLC_DATA_I : rv_core_pkg::PLC_NORMAL;

    always_comb begin
        case (state)
            rv_core_pkg::PLC_NORMAL: next_state = pick;
            rv_core_pkg::PLC_JUMP_P: next_state = rv_core_pkg::PLC_JUMP_I;
            rv_core_pkg::PLC_JUMP_I: begin
                if (!i_ifetch_launch) next_state = rv_core_pkg::PLC_JUMP_I;
                else if (i_ifetch_done) next_state = rv_core_pkg::PLC_NORMAL;  // zero latency
                else next_state = rv_core_pkg::PLC_JUMP_E;
            end
            rv_core_pkg::PLC_JUMP_E: next_state = i_ifetch_done ? pick : state;
            rv_core_pkg::PLC_DATA_I: begin
                if (!i_dbus_launch) next_state = rv_core_pkg::PLC_DATA_I;
                else if (i_store_done) next_state = rv_core_pkg::PLC_NORMAL;
                else next_state = rv_core_pkg::PLC_DATA_E;
            end
            rv_core_pkg::PLC_DATA_E: next_state = i_store_done ? pick : state;
            default: next_state = rv_core_pkg::PLC_NORMAL;
        endcase
    end

    assign o_jmp = (state == rv_core_pkg::PLC_JUMP_P);
    assign o_hld = (state == rv_core_pkg::PLC_JUMP_P) || (state == rv_core_pkg::PLC_JUMP_I) ||
                   (state == rv_core_pkg::PLC_DATA_I) ||
                   (state == rv_core_pkg::PLC_JUMP_E && !i_ifetch_done) ||
                   (state == rv_core_pkg::PLC_DATA_E && !i_store_done);

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rstn,
    output rv_core_pkg::bus_req_t o_ibus,
    input  logic                  i_ibus_resp,
    input  logic [`RV_XLEN-1:0]   i_ibus_rdata,
    output rv_core_pkg::bus_req_t o_dbus,
    input  logic                  i_dbus_resp,
    output logic                  o_core_fault,
    output logic [`RV_XLEN-1:0]   o_core_fault_pc
);

    logic                jmp;
    logic                hld;
    logic [`RV_XLEN-1:0] jmp_addr;
    logic                ifetch_done;
    logic                store_done;
    logic                s1_jump;
    logic                s1_store;
    logic                illegal;
    logic [`RV_XLEN-1:0] s1_pc;
    rv_core_pkg::fetch_t fetch;
    rv_core_pkg::exec_t  exec;
    rv_core_pkg::rf_wr_t rf_wr;

    fetch_unit u_fetch (
        .clk           (clk),
        .rstn          (rstn),
        .i_jmp         (jmp),
        .i_jmp_addr    (jmp_addr),
        .i_hld         (hld),
        .o_ibus        (o_ibus),
        .i_ibus_resp   (i_ibus_resp),
        .i_ibus_rdata  (i_ibus_rdata),
        .o_fetch       (fetch),
        .o_ifetch_done (ifetch_done)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rstn       (rstn),
        .i_jmp      (jmp),
        .i_hld      (hld),
        .i_fetch    (fetch),
        .i_rf_wr    (rf_wr),
        .o_exec     (exec),
        .o_s1_jump  (s1_jump),
        .o_s1_store (s1_store),
        .o_illegal  (illegal),
        .o_s1_pc    (s1_pc)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rstn            (rstn),
        .i_hld           (hld),
        .i_exec          (exec),
        .i_illegal       (illegal),
        .i_s1_pc         (s1_pc),
        .o_rf_wr         (rf_wr),
        .o_jmp_addr      (jmp_addr),
        .o_dbus          (o_dbus),
        .i_dbus_resp     (i_dbus_resp),
        .o_store_done    (store_done),
        .o_core_fault    (o_core_fault),
        .o_core_fault_pc (o_core_fault_pc)
    );

    pipeline_ctrl u_plc (
        .clk             (clk),
        .rstn            (rstn),
        .i_s1_jump       (s1_jump),
        .i_s1_store      (s1_store),
        .i_ifetch_launch (o_ibus.valid),  // request visible on the bus
        .i_ifetch_done   (ifetch_done),
        .i_dbus_launch   (o_dbus.valid),
        .i_store_done    (store_done),
        .o_jmp           (jmp),
        .o_hld           (hld)
    );

endmodule

/* hdl/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and address width
`define RV_XLEN 32
// uncompressed instructions only
`define RV_ILEN 32

// RV32E register file
`define RV_NREG 16
`define RV_REG_IDX_W 4

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* hdl/rv_core_pkg.sv */
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_STD,   // alu result to rd
        WB_LINK,  // return address to rd
        WB_STORE, // nothing written
        WB_JALR   // link, target bit 0 cleared
    } wb_op_e;

    typedef enum logic [2:0] {
        PLC_NORMAL, PLC_JUMP_P, PLC_JUMP_I, PLC_JUMP_E, PLC_DATA_I, PLC_DATA_E
    } plc_state_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] addr;  // byte address
        logic [`RV_XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_ILEN-1:0] ir;
        logic [`RV_XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic                     valid;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_XLEN-1:0]      alu_a;
        logic [`RV_XLEN-1:0]      alu_b;
        alu_op_e                  alu_op;
        wb_op_e                   wb_op;
        logic [`RV_XLEN-1:0]      link;
        logic [`RV_XLEN-1:0]      store_data;
        logic                     is_store;
        logic                     jump;
    } exec_t;

    typedef struct packed {
        logic                     en;
        logic [`RV_REG_IDX_W-1:0] idx;
        logic [`RV_XLEN-1:0]      data;
    } rf_wr_t;

endpackage

/* rv_core.f */
+incdir+hdl
+incdir+test
hdl/rv_core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/pipeline_ctrl.sv
hdl/rv_core.sv
test/tb_rv_core.sv

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} store_t;

localparam int          PROG_LEN   = 46;
localparam int          NUM_STORES = 10;
localparam logic [31:0] FAULT_PC   = 32'h0000_00b4;  // the all-zero word

// instruction word at byte address idx*4
function automatic logic [31:0] prog_word(input logic [31:0] idx);
    case (idx)
        0:  return 32'h123450b7;  // lui  x1, 0x12345
        1:  return 32'h67808093;  // addi x1, x1, 0x678
        2:  return 32'h10102023;  // sw   x1, 0x100(x0)
        3:  return 32'hffb00113;  // addi x2, x0, -5
        4:  return 32'h402081b3;  // sub  x3, x1, x2
        5:  return 32'h10302223;  // sw   x3, 0x104(x0)
        6:  return 32'h0020c233;  // xor  x4, x1, x2
        7:  return 32'h0f027293;  // andi x5, x4, 0x0f0
        8:  return 32'h0032e333;  // or   x6, x5, x3
        9:  return 32'h10602423;  // sw   x6, 0x108(x0)
        10: return 32'h001123b3;  // slt  x7, x2, x1
        11: return 32'h00113433;  // sltu x8, x2, x1
        12: return 32'h00439493;  // slli x9, x7, 4
        13: return 32'h0084e4b3;  // or   x9, x9, x8
        14: return 32'h10902623;  // sw   x9, 0x10c(x0)
        15: return 32'h40115513;  // srai x10, x2, 1
        16: return 32'h01c15593;  // srli x11, x2, 28
        17: return 32'h00b09633;  // sll  x12, x1, x11
        18: return 32'h00c546b3;  // xor  x13, x10, x12
        19: return 32'h10d02823;  // sw   x13, 0x110(x0)
        20: return 32'h40b15733;  // sra  x14, x2, x11
        21: return 32'h00b157b3;  // srl  x15, x2, x11
        22: return 32'h00f70733;  // add  x14, x14, x15
        23: return 32'h10e02a23;  // sw   x14, 0x114(x0)
        24: return 32'h00001297;  // auipc x5, 0x1
        25: return 32'h10502c23;  // sw   x5, 0x118(x0)
        26: return 32'h00038463;  // beq  x7, x0, +8 not taken
        27: return 32'h00039463;  // bne  x7, x0, +8 taken
        28: return 32'h1e102823;  // sw   x1, 0x1f0(x0) skipped
        29: return 32'h00114463;  // blt  x2, x1, +8 taken
        30: return 32'h1e102a23;  // sw   x1, 0x1f4(x0) skipped
        31: return 32'h00115463;  // bge  x2, x1, +8 not taken
        32: return 32'h00c0036f;  // jal  x6, +12
        33: return 32'h1e102c23;  // sw   x1, 0x1f8(x0) skipped
        34: return 32'h1e102e23;  // sw   x1, 0x1fc(x0) skipped
        35: return 32'h10602e23;  // sw   x6, 0x11c(x0)
        36: return 32'h0a100413;  // addi x8, x0, 0xa1
        37: return 32'h000404e7;  // jalr x9, 0(x8) lands on 0xa0
        38: return 32'h1e102023;  // sw   x1, 0x1e0(x0) skipped
        39: return 32'h1e102223;  // sw   x1, 0x1e4(x0) skipped
        40: return 32'h12902023;  // sw   x9, 0x120(x0)
        41: return 32'h00117463;  // bgeu x2, x1, +8 taken
        42: return 32'h1e102423;  // sw   x1, 0x1e8(x0) skipped
        43: return 32'h13000513;  // addi x10, x0, 0x130
        44: return 32'hfe852a23;  // sw   x8, -12(x10)
        default: return 32'h00000000;  // illegal from 0xb4 on
    endcase
endfunction

// stores on the architectural path, in order
function automatic store_t expected_store(input int idx);
    case (idx)
        0: return {32'h0000_0100, 32'h1234_5678};
        1: return {32'h0000_0104, 32'h1234_567d};
        2: return {32'h0000_0108, 32'h1234_56fd};
        3: return {32'h0000_010c, 32'h0000_0010};  // slt=1, sltu=0
        4: return {32'h0000_0110, 32'hd4c3_fffd};
        5: return {32'h0000_0114, 32'h0001_fffe};
        6: return {32'h0000_0118, 32'h0000_1060};  // auipc at 0x60
        7: return {32'h0000_011c, 32'h0000_0084};  // jal link
        8: return {32'h0000_0120, 32'h0000_0098};  // jalr link
        9: return {32'h0000_0124, 32'h0000_00a1};
        default: return '0;
    endcase
endfunction

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module tb_rv_core;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED    = 32'h3cb3f66e;

    `include "tb_program.svh"

    localparam int WATCHDOG_CYCLES = (PROG_LEN + NUM_STORES) * 40;

    logic                  clk = 1'b0;
    logic                  rstn;
    rv_core_pkg::bus_req_t ibus;
    logic                  ibus_resp;
    logic [`RV_XLEN-1:0]   ibus_rdata;
    rv_core_pkg::bus_req_t dbus;
    logic                  dbus_resp;
    logic                  core_fault;
    logic [`RV_XLEN-1:0]   core_fault_pc;
    logic [31:0]           ibus_lfsr;
    logic [31:0]           dbus_lfsr;
    int                    errors = 0;

    rv_core uut (
        .clk             (clk),
        .rstn            (rstn),
        .o_ibus          (ibus),
        .i_ibus_resp     (ibus_resp),
        .i_ibus_rdata    (ibus_rdata),
        .o_dbus          (dbus),
        .i_dbus_resp     (dbus_resp),
        .o_core_fault    (core_fault),
        .o_core_fault_pc (core_fault_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_latency(inout logic [31:0] state, output int lat);
        lat = 0;
        repeat (2) begin
            lat   = (lat << 1) | state[0];  // one step per bit
            state = lfsr_step(state);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;  // outputs settled, inputs change here
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic answer_fetch;
        logic [31:0] addr;
        int          lat;
        addr = ibus.addr;
        draw_latency(ibus_lfsr, lat);
        repeat (lat) begin
            next_cycle();
            check_value("o_ibus.valid", ibus.valid, 1'b1);  // request must hold
            check_value("o_ibus.addr", ibus.addr, addr);
        end
        ibus_rdata = prog_word(addr >> 2);
        ibus_resp  = 1'b1;
        next_cycle();
        ibus_resp  = 1'b0;
    endtask

    task automatic answer_store;
        logic [31:0] addr;
        logic [31:0] data;
        int          lat;
        addr = dbus.addr;
        data = dbus.wdata;
        draw_latency(dbus_lfsr, lat);
        repeat (lat) begin
            next_cycle();
            check_value("o_dbus.valid", dbus.valid, 1'b1);
            check_value("o_dbus.addr", dbus.addr, addr);
            check_value("o_dbus.wdata", dbus.wdata, data);
        end
        dbus_resp = 1'b1;
        next_cycle();
        dbus_resp = 1'b0;
    endtask

    // instruction memory, one fetch at a time
    always begin
        next_cycle();
        if (rstn && ibus.valid) begin
            answer_fetch();
        end
    end

    initial begin : main_seq
        store_t exp;
        int     cycles;
        logic   extra;
        rstn       = 1'b0;
        ibus_resp  = 1'b0;
        ibus_rdata = '0;
        dbus_resp  = 1'b0;
        ibus_lfsr  = LFSR_SEED;
        dbus_lfsr  = LFSR_SEED;
        repeat (RESET_CYCLES) next_cycle();
        check_value("o_dbus.valid", dbus.valid, 1'b0);
        check_value("o_core_fault", core_fault, 1'b0);
        rstn = 1'b1;

        cycles = 0;
        while (!ibus.valid && cycles < 2) begin
            next_cycle();
            cycles++;
        end
        if (!ibus.valid) begin
            errors++;
            $display("no instruction fetch within 2 cycles after reset");
        end else begin
            check_value("o_ibus.addr", ibus.addr, `RV_RESET_PC);
        end

        for (int i = 0; i < NUM_STORES; i++) begin
            exp = expected_store(i);
            while (!dbus.valid) begin
                next_cycle();
            end
            check_value("o_dbus.addr", dbus.addr, exp.addr);
            check_value("o_dbus.wdata", dbus.wdata, exp.data);
            answer_store();
        end

        // nothing may be stored once the table is done
        extra = 1'b0;
        repeat (40) begin
            next_cycle();
            if (dbus.valid && !extra) begin
                extra = 1'b1;
                errors++;
                $display("store request to %h after the last expected store", dbus.addr);
            end
        end
        check_value("o_core_fault", core_fault, 1'b1);
        check_value("o_core_fault_pc", core_fault_pc, FAULT_PC);

        $display("%0d stores checked, %0d errors", NUM_STORES, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule
